//--- hw/upsample_config.svh
`ifndef UPSAMPLE_CONFIG_SVH
`define UPSAMPLE_CONFIG_SVH

// pixel and sum widths
`define UPS_PIXEL_W 8
`define UPS_SUM_W (`UPS_PIXEL_W + 2)

// input buffer holds up to 64x64
`define UPS_IN_ADDR_W 12
`define UPS_BUF_DEPTH (1 << `UPS_IN_ADDR_W)

// output grid up to 128x128
`define UPS_OUT_ADDR_W 14
`define UPS_COORD_W 8

// size code, N = 4 << code
`define UPS_SIZE_W 3
`define UPS_MAX_SIZE 3'd4

`endif

//--- hw/upsample_types_pkg.sv
`include "upsample_config.svh"

package upsample_types_pkg;

    // one greyscale pixel
    typedef logic [`UPS_PIXEL_W-1:0] pixel_t;

    // row * N + col in the source image
    typedef logic [`UPS_IN_ADDR_W-1:0] in_addr_t;

    // raster index over the 2N x 2N output
    typedef logic [`UPS_OUT_ADDR_W-1:0] out_addr_t;

    // output row or column counter
    typedef logic [`UPS_COORD_W-1:0] coord_t;

    // 0..4 valid, rest rejected
    typedef logic [`UPS_SIZE_W-1:0] size_code_t;

endpackage

//--- hw/upsample_ctrl_pkg.sv
package upsample_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SCAN,
        DONE
    } ctrl_state_t;

    // row band (top, mid, bottom) x column band (left, mid, right)
    typedef enum logic [3:0] {
        TOP_LEFT,
        TOP_MID,
        TOP_RIGHT,
        MID_LEFT,
        MID_MID,
        MID_RIGHT,
        BOT_LEFT,
        BOT_MID,
        BOT_RIGHT
    } edge_mode_t;

endpackage

//--- hw/pixel_buffer.sv
`timescale 1ns/1ns
`include "upsample_config.svh"

module pixel_buffer (
    input  logic                        clk,
    input  logic                        wr_en,
    input  upsample_types_pkg::in_addr_t wr_addr,
    input  upsample_types_pkg::pixel_t   wr_data,
    input  upsample_types_pkg::in_addr_t rd_addr0,
    input  upsample_types_pkg::in_addr_t rd_addr1,
    input  upsample_types_pkg::in_addr_t rd_addr2,
    input  upsample_types_pkg::in_addr_t rd_addr3,
    output upsample_types_pkg::pixel_t   rd_data0,
    output upsample_types_pkg::pixel_t   rd_data1,
    output upsample_types_pkg::pixel_t   rd_data2,
    output upsample_types_pkg::pixel_t   rd_data3
);

    upsample_types_pkg::pixel_t mem [`UPS_BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // all four ports read every cycle, data one clock later
    always_ff @(posedge clk) begin
        rd_data0 <= mem[rd_addr0];
        rd_data1 <= mem[rd_addr1];
        rd_data2 <= mem[rd_addr2];
        rd_data3 <= mem[rd_addr3];
    end

endmodule

//--- hw/upsample_scan_ctrl.sv
`timescale 1ns/1ns
`include "upsample_config.svh"

module upsample_scan_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  upsample_types_pkg::size_code_t size,
    output logic                          busy,
    output logic                          done,
    output logic                          issue,
    output upsample_types_pkg::out_addr_t  issue_addr,
    output upsample_types_pkg::in_addr_t   rd_addr0,
    output upsample_types_pkg::in_addr_t   rd_addr1,
    output upsample_types_pkg::in_addr_t   rd_addr2,
    output upsample_types_pkg::in_addr_t   rd_addr3
);

    upsample_ctrl_pkg::ctrl_state_t state;
    upsample_ctrl_pkg::edge_mode_t  mode;
    upsample_types_pkg::size_code_t size_q;
    upsample_types_pkg::coord_t     row;
    upsample_types_pkg::coord_t     col;
    upsample_types_pkg::coord_t     last_pos;
    upsample_types_pkg::coord_t     i_src;
    upsample_types_pkg::coord_t     j_src;
    upsample_types_pkg::coord_t     i_nb;
    upsample_types_pkg::coord_t     j_nb;
    upsample_types_pkg::out_addr_t  out_cnt;
    upsample_types_pkg::in_addr_t   a_ij;
    upsample_types_pkg::in_addr_t   a_ij1;
    upsample_types_pkg::in_addr_t   a_i1j;
    upsample_types_pkg::in_addr_t   a_i1j1;
    logic [2:0]                     n_shift;
    logic                           drained;
    logic                           accept;
    logic                           scan_end;
    logic                           row_odd;
    logic                           col_odd;
    logic                           row_clamp;
    logic                           col_clamp;

    assign accept   = start && (state == upsample_ctrl_pkg::IDLE) && (size <= `UPS_MAX_SIZE);
    assign last_pos = (upsample_types_pkg::coord_t'(8) << size_q) - 1'b1; // 2N-1
    assign n_shift  = size_q + 3'd2; // log2(N)
    assign scan_end = (row == last_pos) && (col == last_pos);

    assign busy       = (state != upsample_ctrl_pkg::IDLE);
    assign issue      = (state == upsample_ctrl_pkg::SCAN);
    assign issue_addr = out_cnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= upsample_ctrl_pkg::IDLE;
            size_q  <= '0;
            row     <= '0;
            col     <= '0;
            out_cnt <= '0;
            drained <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                upsample_ctrl_pkg::IDLE: begin
                    if (accept) begin
                        size_q <= size;
                        state  <= upsample_ctrl_pkg::LOAD;
                    end
                end
                upsample_ctrl_pkg::LOAD: begin
                    row     <= '0;
                    col     <= '0;
                    out_cnt <= '0;
                    drained <= 1'b0;
                    state   <= upsample_ctrl_pkg::SCAN;
                end
                upsample_ctrl_pkg::SCAN: begin
                    out_cnt <= out_cnt + 1'b1;
                    if (col == last_pos) begin
                        col <= '0;
                        row <= row + 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                    if (scan_end) state <= upsample_ctrl_pkg::DONE;
                end
                upsample_ctrl_pkg::DONE: begin
                    // two cycles for the interpolator pipeline to empty
                    drained <= 1'b1;
                    if (drained) begin
                        done  <= 1'b1;
                        state <= upsample_ctrl_pkg::IDLE;
                    end
                end
                default: state <= upsample_ctrl_pkg::IDLE;
            endcase
        end
    end

    always_comb begin
        if (row == '0) begin
            if (col == '0)           mode = upsample_ctrl_pkg::TOP_LEFT;
            else if (col == last_pos) mode = upsample_ctrl_pkg::TOP_RIGHT;
            else                      mode = upsample_ctrl_pkg::TOP_MID;
        end else if (row == last_pos) begin
            if (col == '0)           mode = upsample_ctrl_pkg::BOT_LEFT;
            else if (col == last_pos) mode = upsample_ctrl_pkg::BOT_RIGHT;
            else                      mode = upsample_ctrl_pkg::BOT_MID;
        end else begin
            if (col == '0)           mode = upsample_ctrl_pkg::MID_LEFT;
            else if (col == last_pos) mode = upsample_ctrl_pkg::MID_RIGHT;
            else                      mode = upsample_ctrl_pkg::MID_MID;
        end
    end

    // border bands fix the parity, bottom/right also clamp the neighbour
    always_comb begin
        row_odd   = row[0];
        row_clamp = 1'b0;
        col_odd   = col[0];
        col_clamp = 1'b0;
        case (mode)
            upsample_ctrl_pkg::TOP_LEFT, upsample_ctrl_pkg::TOP_MID,
            upsample_ctrl_pkg::TOP_RIGHT: row_odd = 1'b0;
            upsample_ctrl_pkg::BOT_LEFT, upsample_ctrl_pkg::BOT_MID,
            upsample_ctrl_pkg::BOT_RIGHT: begin
                row_odd   = 1'b1;
                row_clamp = 1'b1;
            end
            default: ;
        endcase
        case (mode)
            upsample_ctrl_pkg::TOP_LEFT, upsample_ctrl_pkg::MID_LEFT,
            upsample_ctrl_pkg::BOT_LEFT: col_odd = 1'b0;
            upsample_ctrl_pkg::TOP_RIGHT, upsample_ctrl_pkg::MID_RIGHT,
            upsample_ctrl_pkg::BOT_RIGHT: begin
                col_odd   = 1'b1;
                col_clamp = 1'b1;
            end
            default: ;
        endcase
    end

    assign i_src = row >> 1;
    assign j_src = col >> 1;
    assign i_nb  = row_clamp ? i_src : i_src + 1'b1;
    assign j_nb  = col_clamp ? j_src : j_src + 1'b1;

    assign a_ij   = (upsample_types_pkg::in_addr_t'(i_src) << n_shift)
                  + upsample_types_pkg::in_addr_t'(j_src);
    assign a_ij1  = (upsample_types_pkg::in_addr_t'(i_src) << n_shift)
                  + upsample_types_pkg::in_addr_t'(j_nb);
    assign a_i1j  = (upsample_types_pkg::in_addr_t'(i_nb) << n_shift)
                  + upsample_types_pkg::in_addr_t'(j_src);
    assign a_i1j1 = (upsample_types_pkg::in_addr_t'(i_nb) << n_shift)
                  + upsample_types_pkg::in_addr_t'(j_nb);

    always_comb begin
        rd_addr0 = a_ij;
        case ({row_odd, col_odd})
            2'b01: begin
                rd_addr1 = a_ij1;
                rd_addr2 = a_ij;
                rd_addr3 = a_ij1;
            end
            2'b10: begin
                rd_addr1 = a_i1j;
                rd_addr2 = a_ij;
                rd_addr3 = a_i1j;
            end
            2'b11: begin
                rd_addr1 = a_ij1;
                rd_addr2 = a_i1j;
                rd_addr3 = a_i1j1;
            end
            default: begin // straight copy
                rd_addr1 = a_ij;
                rd_addr2 = a_ij;
                rd_addr3 = a_ij;
            end
        endcase
    end

endmodule

//--- hw/bilinear_interp.sv
`timescale 1ns/1ns
`include "upsample_config.svh"

module bilinear_interp (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         issue,
    input  upsample_types_pkg::out_addr_t issue_addr,
    input  upsample_types_pkg::pixel_t    rd_data0,
    input  upsample_types_pkg::pixel_t    rd_data1,
    input  upsample_types_pkg::pixel_t    rd_data2,
    input  upsample_types_pkg::pixel_t    rd_data3,
    output logic                         out_valid,
    output upsample_types_pkg::out_addr_t out_addr,
    output upsample_types_pkg::pixel_t    out_pixel
);

    logic                          issue_d;
    upsample_types_pkg::out_addr_t addr_d;
    logic [`UPS_SUM_W-1:0]         sum;

    // +2 rounds the divide by four
    assign sum = `UPS_SUM_W'(rd_data0) + `UPS_SUM_W'(rd_data1)
               + `UPS_SUM_W'(rd_data2) + `UPS_SUM_W'(rd_data3)
               + `UPS_SUM_W'(2);

    // stage 1 lines up with the buffer read latency
    always_ff @(posedge clk) begin
        if (!rst) begin
            issue_d <= 1'b0;
        end else begin
            issue_d <= issue;
        end
    end

    always_ff @(posedge clk) begin
        addr_d <= issue_addr;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= issue_d;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_d) begin
            out_addr  <= addr_d;
            out_pixel <= sum[`UPS_SUM_W-1:2];
        end
    end

endmodule

//--- hw/upsample_top.sv
`timescale 1ns/1ns
`include "upsample_config.svh"

module upsample_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en,
    input  upsample_types_pkg::in_addr_t   wr_addr,
    input  upsample_types_pkg::pixel_t     wr_data,
    input  logic                          start,
    input  upsample_types_pkg::size_code_t size,
    output logic                          busy,
    output logic                          done,
    output logic                          out_valid,
    output upsample_types_pkg::out_addr_t  out_addr,
    output upsample_types_pkg::pixel_t     out_pixel
);

    logic                          buf_wr_en;
    logic                          issue;
    upsample_types_pkg::out_addr_t issue_addr;
    upsample_types_pkg::in_addr_t  rd_addr0;
    upsample_types_pkg::in_addr_t  rd_addr1;
    upsample_types_pkg::in_addr_t  rd_addr2;
    upsample_types_pkg::in_addr_t  rd_addr3;
    upsample_types_pkg::pixel_t    rd_data0;
    upsample_types_pkg::pixel_t    rd_data1;
    upsample_types_pkg::pixel_t    rd_data2;
    upsample_types_pkg::pixel_t    rd_data3;

    assign buf_wr_en = wr_en & ~busy; // image frozen during a scan

    pixel_buffer u_buf (
        .clk      (clk),
        .wr_en    (buf_wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr0 (rd_addr0),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_addr3 (rd_addr3),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .rd_data3 (rd_data3)
    );

    upsample_scan_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .size       (size),
        .busy       (busy),
        .done       (done),
        .issue      (issue),
        .issue_addr (issue_addr),
        .rd_addr0   (rd_addr0),
        .rd_addr1   (rd_addr1),
        .rd_addr2   (rd_addr2),
        .rd_addr3   (rd_addr3)
    );

    bilinear_interp u_interp (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .issue_addr (issue_addr),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1),
        .rd_data2   (rd_data2),
        .rd_data3   (rd_data3),
        .out_valid  (out_valid),
        .out_addr   (out_addr),
        .out_pixel  (out_pixel)
    );

endmodule

//--- tests/upsample_props.sv
`timescale 1ns/1ns

module upsample_props (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done,
    input logic strobe
);

    done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
        else $error("done stayed high for a second cycle");

    // no strobe in idle or in the load cycle
    strobe_scan: assert property (@(posedge clk) disable iff (!rst)
        strobe |-> busy && $past(busy))
        else $error("strobe high outside the scan");

endmodule

bind upsample_scan_ctrl upsample_props ctrl_props (
    .clk    (clk),
    .rst    (rst),
    .busy   (busy),
    .done   (done),
    .strobe (issue)
);

bind upsample_top upsample_props top_props (
    .clk    (clk),
    .rst    (rst),
    .busy   (busy),
    .done   (done),
    .strobe (out_valid) // output stream inside busy
);

//--- tests/upsample_tb.sv
`timescale 1ns/1ns
`include "upsample_config.svh"

module upsample_tb;

    // image load + 4N^2 outputs + slack, per scan
    localparam int BUDGET = 60 + 5 * (16 + 64 + 256 + 64 + 64 + 4096) + 6 * 20;
    localparam int CYCLE_LIMIT = 2 * BUDGET;

    logic                           clk;
    logic                           rst;
    logic                           wr_en;
    upsample_types_pkg::in_addr_t   wr_addr;
    upsample_types_pkg::pixel_t     wr_data;
    logic                           start;
    upsample_types_pkg::size_code_t size;
    logic                           busy;
    logic                           done;
    logic                           out_valid;
    upsample_types_pkg::out_addr_t  out_addr;
    upsample_types_pkg::pixel_t     out_pixel;

    upsample_types_pkg::pixel_t    image [`UPS_BUF_DEPTH]; // reference copy
    upsample_types_pkg::out_addr_t got_addr [$];
    upsample_types_pkg::pixel_t    got_pix [$];
    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int start_edge;
    int first_valid;
    int last_valid;
    int done_cyc;
    int done_count;
    logic done_busy;

    upsample_top UUT (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .start     (start),
        .size      (size),
        .busy      (busy),
        .done      (done),
        .out_valid (out_valid),
        .out_addr  (out_addr),
        .out_pixel (out_pixel)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (start && !busy) start_edge = cycle + 1; // edge that samples start
        if (out_valid) begin
            if (first_valid < 0) first_valid = cycle;
            last_valid = cycle;
            got_addr.push_back(out_addr);
            got_pix.push_back(out_pixel);
        end
        if (done) begin
            done_cyc = cycle;
            done_busy = busy;
            done_count++;
        end
    end

    task automatic compare_hex(input string sig, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s got %h expected %h at cycle %0d", sig, got, exp, cycle);
            errors++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("failure at cycle %0d: %s", cycle, what);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - err_before);
    endtask

    // neighbour rule with clamping at N-1, rounded average of four
    function automatic upsample_types_pkg::pixel_t model_pixel(input int n, input int r, input int c);
        int i;
        int j;
        int i1;
        int j1;
        int s;
        i = r / 2;
        j = c / 2;
        i1 = (i + 1 > n - 1) ? n - 1 : i + 1;
        j1 = (j + 1 > n - 1) ? n - 1 : j + 1;
        if (r % 2 == 0 && c % 2 == 0)
            s = 4 * image[i * n + j];
        else if (r % 2 == 0)
            s = 2 * (image[i * n + j] + image[i * n + j1]);
        else if (c % 2 == 0)
            s = 2 * (image[i * n + j] + image[i1 * n + j]);
        else
            s = image[i * n + j] + image[i * n + j1] + image[i1 * n + j] + image[i1 * n + j1];
        return upsample_types_pkg::pixel_t'((s + 2) / 4);
    endfunction

    task automatic fill_random(input int n);
        int a;
        for (a = 0; a < n * n; a++) image[a] = upsample_types_pkg::pixel_t'($urandom());
    endtask

    task automatic fill_const(input int n, input upsample_types_pkg::pixel_t v);
        int a;
        for (a = 0; a < n * n; a++) image[a] = v;
    endtask

    task automatic write_image(input int n);
        int a;
        for (a = 0; a < n * n; a++) begin
            @(posedge clk);
            wr_en <= 1'b1;
            wr_addr <= upsample_types_pkg::in_addr_t'(a);
            wr_data <= image[a];
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic clear_capture();
        got_addr.delete();
        got_pix.delete();
        start_edge = -1;
        first_valid = -1;
        last_valid = -1;
        done_count = 0;
    endtask

    task automatic pulse_start(input upsample_types_pkg::size_code_t code);
        @(posedge clk);
        start <= 1'b1;
        size <= code;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(input int n);
        int waited;
        waited = 0;
        while (done_count == 0 && waited < 4 * n * n + 20) begin
            @(negedge clk);
            waited++;
        end
        require(done_count > 0, "done never pulsed after start");
    endtask

    task automatic check_scan(input int n);
        int k;
        compare_hex("out_valid count", got_pix.size(), 4 * n * n);
        for (k = 0; k < got_pix.size(); k++) begin
            compare_hex("out_addr", got_addr[k], k);
            compare_hex("out_pixel", got_pix[k], model_pixel(n, k / (2 * n), k % (2 * n)));
        end
    endtask

    task automatic reset_and_bad_size();
        int err0;
        int k;
        err0 = errors;
        clear_capture();
        @(negedge clk);
        compare_hex("busy", busy, 0);
        compare_hex("done", done, 0);
        compare_hex("out_valid", out_valid, 0);
        pulse_start(3'd6); // codes above 4 are rejected
        for (k = 0; k < 20; k++) begin
            @(negedge clk);
            require(!busy, "start with size code 6 raised busy");
        end
        finish_test("reset and bad size", err0);
    endtask

    task automatic random_scan(input int n, input upsample_types_pkg::size_code_t code,
                               input string name);
        int err0;
        err0 = errors;
        fill_random(n);
        write_image(n);
        clear_capture();
        pulse_start(code);
        wait_done(n);
        check_scan(n);
        finish_test(name, err0);
    endtask

    task automatic constant_image();
        int err0;
        int k;
        err0 = errors;
        fill_const(8, 8'h5a);
        write_image(8);
        clear_capture();
        pulse_start(3'd1);
        wait_done(8);
        check_scan(8);
        for (k = 0; k < got_pix.size(); k++) compare_hex("out_pixel", got_pix[k], 8'h5a);
        finish_test("constant 8x8", err0);
    endtask

    task automatic timing_size2();
        int err0;
        err0 = errors;
        fill_random(16);
        write_image(16);
        clear_capture();
        pulse_start(3'd2);
        wait_done(16);
        compare_hex("first out_valid cycle", first_valid, start_edge + 3);
        compare_hex("out_valid run length", last_valid - first_valid + 1, 1024);
        compare_hex("done cycle", done_cyc, last_valid + 1);
        compare_hex("busy with done", done_busy, 0);
        @(negedge clk);
        compare_hex("done pulse count", done_count, 1);
        check_scan(16);
        finish_test("timing size 2", err0);
    endtask

    task automatic frozen_image();
        int err0;
        int k;
        err0 = errors;
        fill_random(8);
        write_image(8);
        clear_capture();
        pulse_start(3'd1);
        @(negedge clk);
        require(busy, "busy did not rise after start");
        for (k = 0; k < 8; k++) begin
            @(posedge clk);
            wr_en <= 1'b1;
            wr_addr <= upsample_types_pkg::in_addr_t'(k * 7);
            wr_data <= ~image[k * 7];
        end
        @(posedge clk);
        wr_en <= 1'b0;
        pulse_start(3'd0); // lands mid scan
        wait_done(8);
        check_scan(8);
        repeat (5) @(negedge clk);
        require(!busy && done_count == 1, "start while busy began another scan");
        clear_capture();
        pulse_start(3'd1);
        wait_done(8);
        check_scan(8);
        finish_test("writes and start while busy", err0);
    endtask

    initial begin
        void'($urandom(32'h0ddd_d365));
        rst = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        start = 1'b0;
        size = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        reset_and_bad_size();
        random_scan(4, 3'd0, "random 4x4");
        constant_image();
        timing_size2();
        frozen_image();
        random_scan(64, 3'd4, "random 64x64");
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+hw
hw/upsample_types_pkg.sv
hw/upsample_ctrl_pkg.sv
hw/pixel_buffer.sv
hw/upsample_scan_ctrl.sv
hw/bilinear_interp.sv
hw/upsample_top.sv
tests/upsample_props.sv
tests/upsample_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= upsample_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) hw/upsample_config.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
